/* verification/led_board_cases.txt */
# Actions: press <center|up|down|left|right>, user <hex byte>, frame <count>
# Checks: expect <pixel index> <color as hex, green red blue>
frame 1
expect 0 000000
expect 3 000000
user a5
press up
press right
user 3c
press up
press center
frame 2
expect 0 a53c00
expect 1 000000
press down
press right
user 0f
press up
press center
press down
press down
press right
user 11
press up
press center
press down
press left
user ff
press up
press center
frame 2
expect 0 113cff
expect 1 a53c0f
expect 2 000000
expect 3 113c0f

/* project.f */
+incdir+design
design/led_board_pkg.sv
design/rst_ctrl.sv
design/sw_sync.sv
design/pixel_ram.sv
design/pixel_arbiter.sv
design/pixel_editor.sv
design/ws281x_drv.sv
design/led_board_top.sv
verification/led_board_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the LED board testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f project.f \
  --top-module led_board_tb -o led_board_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/led_board_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Everything OK$" "$SIM_LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

/* verification/led_board_tb.sv */
/*
 * Self-checking testbench for the LED board top level. Reads actions and
 * expected pixel colors from the case file, decodes the WS281x stream
 * from the RGB LED pin and checks it against a model of the editor.
 */
`timescale 1ns/1ps
`default_nettype none

`include "led_board_defs.svh"

module led_board_tb;

  localparam string CASE_FILE = "verification/led_board_cases.txt";
  localparam int    PIX_BITS  = `LED_COUNT * 24;
  localparam int    HIGH_MID  = (`WS_T0H_CYCLES + `WS_T1H_CYCLES) / 2;
  localparam int    OP_PRESS  = 0;
  localparam int    OP_USER   = 1;
  localparam int    OP_FRAME  = 2;
  localparam int    OP_EXPECT = 3;

  logic       main_clk_buf;
  logic       rst_sys_n;
  logic [4:0] nav_sw_ni;
  logic [7:0] usr_sw_ni;
  logic [7:0] usr_led_o;
  logic       led_bootok_o;
  logic       rgbled_o;

  // Parsed case file.
  int          op_kind[$];
  int          op_arg[$];
  logic [23:0] op_color[$];

  // Reference model of the editor and the frame memory.
  int          m_chan;
  int          m_idx;
  logic [23:0] m_color;
  logic [7:0]  m_user;
  logic [23:0] pix_model [`LED_COUNT];

  // Stream decoder state.
  logic        dout;
  logic        prev_dout;
  logic        bit_v;
  logic [23:0] shift_v;
  int          hi_cnt;
  int          lo_cnt;
  int          bit_cnt;
  int          frame_cnt;
  bit          gap_open;
  logic [23:0] frame_pix [`LED_COUNT];
  logic [23:0] dec_pix [`LED_COUNT];

  int check_cnt;
  int err_cnt;
  int cyc;
  int limit;

  led_board_top led_board_top_inst (
    .main_clk_buf(main_clk_buf),
    .rst_sys_n   (rst_sys_n),
    .nav_sw_ni   (nav_sw_ni),
    .usr_sw_ni   (usr_sw_ni),
    .usr_led_o   (usr_led_o),
    .led_bootok_o(led_bootok_o),
    .rgbled_o    (rgbled_o)
  );

  initial begin
    main_clk_buf = 1'b0;
    forever #20 main_clk_buf = ~main_clk_buf;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic int nav_bit(input string name);
    if (name == "center") return 0;
    else if (name == "up") return 1;
    else if (name == "down") return 2;
    else if (name == "left") return 3;
    else if (name == "right") return 4;
    else return -1;
  endfunction

  task automatic load_cases(output bit ok);
    int          fd;
    int          n;
    int          a;
    bit          bad;
    string       line;
    string       word;
    string       arg;
    logic [23:0] b;
    ok = 1'b1;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the case file %s", CASE_FILE);
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        word = "";
        bad  = 1'b0;
        a    = 0;
        b    = '0;
        n    = $fgets(line, fd);
        if (n > 0) begin
          n = $sscanf(line, "%s", word);
        end
        if (n == 1 && word != "#") begin
          if (word == "press") begin
            n = $sscanf(line, "%s %s", word, arg);
            a = nav_bit(arg);
            bad = (n != 2) || (a < 0);
            op_kind.push_back(OP_PRESS);
          end else if (word == "user") begin
            n = $sscanf(line, "%s %h", word, b);
            bad = (n != 2);
            op_kind.push_back(OP_USER);
          end else if (word == "frame") begin
            n = $sscanf(line, "%s %d", word, a);
            bad = (n != 2) || (a < 1);
            op_kind.push_back(OP_FRAME);
          end else if (word == "expect") begin
            n = $sscanf(line, "%s %d %h", word, a, b);
            bad = (n != 3) || (a < 0) || (a >= `LED_COUNT);
            op_kind.push_back(OP_EXPECT);
          end else begin
            bad = 1'b1;
          end
          op_arg.push_back(a);
          op_color.push_back(b);
          if (bad) begin
            $display("The case file has a line that cannot be read: %s", line);
            ok = 1'b0;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Applies one navigation press to the model, as the editor would.
  task automatic model_press(input int bit_pos);
    case (bit_pos)
      0: pix_model[m_idx] = m_color;
      1: m_color[23 - 8 * m_chan -: 8] = m_user;
      2: m_idx = (m_idx + 1) % `LED_COUNT;
      3: m_chan = (m_chan == 0) ? 2 : m_chan - 1;
      default: m_chan = (m_chan == 2) ? 0 : m_chan + 1;
    endcase
  endtask

  task automatic press_switch(input int bit_pos);
    logic [7:0] exp_led;
    @(negedge main_clk_buf);
    nav_sw_ni[bit_pos] = 1'b0;
    model_press(bit_pos);
    exp_led = {m_chan[1:0], m_idx[1:0], 4'b0000};
    repeat (4) @(negedge main_clk_buf);
    check_value("usr_led_o", 32'(usr_led_o), 32'(exp_led));
    nav_sw_ni[bit_pos] = 1'b1;
    // Lets the pulse pass and any write request finish.
    repeat (4) @(negedge main_clk_buf);
  endtask

  task automatic set_user(input logic [7:0] val);
    @(negedge main_clk_buf);
    usr_sw_ni = ~val;
    m_user    = val;
    repeat (4) @(negedge main_clk_buf);
  endtask

  task automatic wait_frames(input int count);
    int target;
    target = frame_cnt + count;
    while (frame_cnt < target) @(posedge main_clk_buf);
    for (int i = 0; i < `LED_COUNT; i++) begin
      check_value($sformatf("frame pixel %0d", i), 32'(dec_pix[i]), 32'(pix_model[i]));
    end
  endtask

  task automatic expect_pixel(input int idx, input logic [23:0] color);
    check_value($sformatf("model pixel %0d", idx), 32'(pix_model[idx]), 32'(color));
    check_value($sformatf("pixel %0d", idx), 32'(dec_pix[idx]), 32'(color));
  endtask

  // WS281x decoder on the pin, sampled away from the active clock edge.
  always @(negedge main_clk_buf) begin
    dout = ~rgbled_o;
    if (!led_bootok_o) begin
      check_value("rgbled_o idle", 32'(rgbled_o), 32'd1);
    end else if (dout) begin
      if (!prev_dout) begin
        if (gap_open) begin
          check_value("gap clocks",
                      (lo_cnt >= `WS_RESET_CYCLES) ? `WS_RESET_CYCLES : lo_cnt,
                      `WS_RESET_CYCLES);
          gap_open = 1'b0;
        end
        hi_cnt = 0;
      end
      hi_cnt++;
      lo_cnt = 0;
    end else begin
      if (prev_dout) begin
        bit_v   = (hi_cnt > HIGH_MID);
        shift_v = {shift_v[22:0], bit_v};
        bit_cnt++;
        if (bit_cnt % 24 == 0 && bit_cnt <= PIX_BITS) begin
          frame_pix[bit_cnt / 24 - 1] = shift_v;
        end
      end
      lo_cnt++;
      // A low run longer than one bit closes the frame.
      if (lo_cnt == `WS_BIT_CYCLES + 1 && bit_cnt > 0) begin
        check_value("frame bits", bit_cnt, PIX_BITS);
        for (int i = 0; i < `LED_COUNT; i++) begin
          dec_pix[i] = frame_pix[i];
        end
        frame_cnt++;
        bit_cnt  = 0;
        gap_open = 1'b1;
      end
    end
    prev_dout = dout;
  end

  always @(posedge main_clk_buf) begin
    cyc++;
    if (limit > 0 && cyc >= limit) begin
      $display("Timeout: the run did not finish within %0d clocks", limit);
      $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    bit ok;
    int n;
    rst_sys_n = 1'b0;
    nav_sw_ni = 5'h1f;
    usr_sw_ni = 8'hff;
    m_chan    = 0;
    m_idx     = 0;
    m_color   = '0;
    m_user    = '0;
    prev_dout = 1'b0;
    shift_v   = '0;
    hi_cnt    = 0;
    lo_cnt    = 0;
    bit_cnt   = 0;
    frame_cnt = 0;
    gap_open  = 1'b0;
    check_cnt = 0;
    err_cnt   = 0;
    cyc       = 0;
    limit     = 0;
    for (int i = 0; i < `LED_COUNT; i++) begin
      pix_model[i] = '0;
      frame_pix[i] = '0;
      dec_pix[i]   = '0;
    end
    load_cases(ok);
    if (!ok) begin
      err_cnt++;
    end else begin
      limit = (op_kind.size() + 2) * 3 * 9000;
      repeat (16) begin
        @(negedge main_clk_buf);
        check_value("led_bootok_o", 32'(led_bootok_o), 32'd0);
      end
      rst_sys_n = 1'b1;
      n = 0;
      while (!led_bootok_o && n < 4 * `RST_HOLD_CYCLES) begin
        @(negedge main_clk_buf);
        n++;
      end
      check_value("led_bootok_o release clocks", n, `RST_HOLD_CYCLES + 2);
      for (int i = 0; i < op_kind.size(); i++) begin
        case (op_kind[i])
          OP_PRESS: press_switch(op_arg[i]);
          OP_USER:  set_user(op_color[i][7:0]);
          OP_FRAME: wait_frames(op_arg[i]);
          default:  expect_pixel(op_arg[i], op_color[i]);
        endcase
      end
    end
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/led_board_top.sv */
/*
 * Board top level for the LED subsystem. Wires the reset controller,
 * switch synchronizers, pixel editor, memory arbiter and WS281x driver.
 */
`timescale 1ns/1ps
`default_nettype none

module led_board_top (
  input  logic       main_clk_buf,
  input  logic       rst_sys_n,
  input  logic [4:0] nav_sw_ni,
  input  logic [7:0] usr_sw_ni,
  output logic [7:0] usr_led_o,
  output logic       led_bootok_o,
  output logic       rgbled_o
);
  import led_board_pkg::*;

  logic        rst_core_n;
  nav_sw_t     nav_press;
  usr_sw_t     usr_level;
  logic        drv_req;
  logic        drv_gnt;
  logic        drv_rd_valid;
  pix_idx_t    drv_idx;
  pixel_t      drv_rdata;
  logic        ed_req;
  logic        ed_gnt;
  pix_idx_t    ed_idx;
  pixel_t      ed_wdata;
  logic        ram_en;
  logic        ram_we;
  pix_idx_t    ram_addr;
  pixel_t      ram_wdata;
  pixel_t      ram_rdata;
  color_chan_e ed_chan;
  pix_idx_t    ed_cur_idx;
  logic        ws_dout;

  rst_ctrl u_rst_ctrl (
    .main_clk_buf(main_clk_buf),
    .rst_sys_n   (rst_sys_n),
    .rst_core_no (rst_core_n)
  );

  assign led_bootok_o = rst_core_n;

  sw_sync #(.sw_t(led_board_pkg::nav_sw_t)) u_nav_sync (
    .main_clk_buf(main_clk_buf),
    .rst_core_ni (rst_core_n),
    .sw_pad_ni   (nav_sw_ni),
    .sw_level_o  (),
    .sw_press_o  (nav_press)
  );

  sw_sync #(.sw_t(led_board_pkg::usr_sw_t)) u_usr_sync (
    .main_clk_buf(main_clk_buf),
    .rst_core_ni (rst_core_n),
    .sw_pad_ni   (usr_sw_ni),
    .sw_level_o  (usr_level),
    .sw_press_o  ()
  );

  pixel_editor u_pixel_editor (
    .main_clk_buf(main_clk_buf),
    .rst_core_ni (rst_core_n),
    .nav_press_i (nav_press),
    .usr_level_i (usr_level),
    .ed_req_o    (ed_req),
    .ed_idx_o    (ed_idx),
    .ed_wdata_o  (ed_wdata),
    .ed_gnt_i    (ed_gnt),
    .chan_o      (ed_chan),
    .idx_o       (ed_cur_idx)
  );

  // Editor state on the user LEDs.
  assign usr_led_o = {ed_chan, ed_cur_idx, 4'b0000};

  pixel_arbiter u_pixel_arbiter (
    .main_clk_buf  (main_clk_buf),
    .rst_core_ni   (rst_core_n),
    .drv_req_i     (drv_req),
    .drv_idx_i     (drv_idx),
    .drv_gnt_o     (drv_gnt),
    .drv_rdata_o   (drv_rdata),
    .drv_rd_valid_o(drv_rd_valid),
    .ed_req_i      (ed_req),
    .ed_idx_i      (ed_idx),
    .ed_wdata_i    (ed_wdata),
    .ed_gnt_o      (ed_gnt),
    .ram_en_o      (ram_en),
    .ram_we_o      (ram_we),
    .ram_addr_o    (ram_addr),
    .ram_wdata_o   (ram_wdata),
    .ram_rdata_i   (ram_rdata)
  );

  pixel_ram u_pixel_ram (
    .main_clk_buf(main_clk_buf),
    .rst_core_ni (rst_core_n),
    .en_i        (ram_en),
    .we_i        (ram_we),
    .addr_i      (ram_addr),
    .wdata_i     (ram_wdata),
    .rdata_o     (ram_rdata)
  );

  ws281x_drv u_ws281x_drv (
    .main_clk_buf(main_clk_buf),
    .rst_core_ni (rst_core_n),
    .req_o       (drv_req),
    .idx_o       (drv_idx),
    .gnt_i       (drv_gnt),
    .rdata_i     (drv_rdata),
    .rd_valid_i  (drv_rd_valid),
    .dout_o      (ws_dout),
    .frame_done_o()
  );

  // The board level shifter inverts the data line.
  assign rgbled_o = ~ws_dout;

endmodule

`default_nettype wire

/* design/ws281x_drv.sv */
/*
 * WS281x chain driver. Reads pixels from frame memory one ahead of the
 * pixel being shifted, sends each bit as a timed high pulse and closes
 * every frame with a low latch gap.
 */
`timescale 1ns/1ps
`default_nettype none

`include "led_board_defs.svh"

module ws281x_drv (
  input  logic                    main_clk_buf,
  input  logic                    rst_core_ni,
  output logic                    req_o,
  output led_board_pkg::pix_idx_t idx_o,
  input  logic                    gnt_i,
  input  led_board_pkg::pixel_t   rdata_i,
  input  logic                    rd_valid_i,
  output logic                    dout_o,
  output logic                    frame_done_o
);
  import led_board_pkg::*;

  localparam int TICK_W = $clog2(`WS_RESET_CYCLES);
  localparam logic [TICK_W-1:0] BIT_LAST = TICK_W'(`WS_BIT_CYCLES - 1);
  localparam logic [TICK_W-1:0] GAP_LAST = TICK_W'(`WS_RESET_CYCLES - 1);
  localparam logic [TICK_W-1:0] T0H      = TICK_W'(`WS_T0H_CYCLES);
  localparam logic [TICK_W-1:0] T1H      = TICK_W'(`WS_T1H_CYCLES);
  localparam logic [4:0]        BIT_IDX_LAST = 5'd23;
  localparam pix_idx_t          PIX_LAST = pix_idx_t'(`LED_COUNT - 1);

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_SHIFT,
    ST_GAP
  } state_e;

  state_e            state_q;
  logic              req_q;
  pix_idx_t          idx_q;
  pix_idx_t          pix_cnt_q;
  logic [4:0]        bit_cnt_q;
  logic [TICK_W-1:0] tick_q;
  logic              done_q;
  logic              dout_q;
  logic [23:0]       shift_q;
  pixel_t            buf_q;
  logic              bit_end;

  assign bit_end = (state_q == ST_SHIFT) && (tick_q == BIT_LAST);

  always_ff @(posedge main_clk_buf or negedge rst_core_ni) begin
    if (!rst_core_ni) begin
      state_q   <= ST_FETCH;
      req_q     <= 1'b0;
      idx_q     <= '0;
      pix_cnt_q <= '0;
      bit_cnt_q <= '0;
      tick_q    <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (gnt_i) begin
        req_q <= 1'b0;
      end
      case (state_q)
        ST_FETCH: begin
          if (rd_valid_i) begin
            state_q   <= ST_SHIFT;
            pix_cnt_q <= '0;
            bit_cnt_q <= '0;
            tick_q    <= '0;
            // Prefetch pixel 1 while pixel 0 shifts.
            if (`LED_COUNT > 1) begin
              req_q <= 1'b1;
              idx_q <= pix_idx_t'(1);
            end
          end else if (!req_q) begin
            req_q <= 1'b1;
            idx_q <= '0;
          end
        end
        ST_SHIFT: begin
          if (tick_q == BIT_LAST) begin
            tick_q <= '0;
            if (bit_cnt_q == BIT_IDX_LAST) begin
              bit_cnt_q <= '0;
              if (pix_cnt_q == PIX_LAST) begin
                state_q <= ST_GAP;
              end else begin
                pix_cnt_q <= pix_cnt_q + pix_idx_t'(1);
                if (int'(pix_cnt_q) + 2 < `LED_COUNT) begin
                  req_q <= 1'b1;
                  idx_q <= pix_cnt_q + pix_idx_t'(2);
                end
              end
            end else begin
              bit_cnt_q <= bit_cnt_q + 5'd1;
            end
          end else begin
            tick_q <= tick_q + TICK_W'(1);
          end
        end
        default: begin
          if (tick_q == GAP_LAST) begin
            tick_q  <= '0;
            done_q  <= 1'b1;
            state_q <= ST_FETCH;
          end else begin
            tick_q <= tick_q + TICK_W'(1);
          end
        end
      endcase
    end
  end

  // Pixel payload path.
  always_ff @(posedge main_clk_buf) begin
    if (state_q == ST_FETCH && rd_valid_i) begin
      shift_q <= rdata_i;
    end else if (bit_end) begin
      shift_q <= (bit_cnt_q == BIT_IDX_LAST) ? buf_q : {shift_q[22:0], 1'b0};
    end
    if (state_q == ST_SHIFT && rd_valid_i) begin
      buf_q <= rdata_i;
    end
  end

  // Registered pin drive keeps the output free of decode glitches.
  always_ff @(posedge main_clk_buf or negedge rst_core_ni) begin
    if (!rst_core_ni) begin
      dout_q <= 1'b0;
    end else begin
      dout_q <= (state_q == ST_SHIFT) && (tick_q < (shift_q[23] ? T1H : T0H));
    end
  end

  assign req_o        = req_q;
  assign idx_o        = idx_q;
  assign dout_o       = dout_q;
  assign frame_done_o = done_q;

  gap_low_a: assert property (@(posedge main_clk_buf) disable iff (!rst_core_ni)
    (state_q == ST_GAP) |-> !dout_o);

endmodule

`default_nettype wire

/* design/pixel_editor.sv */
/*
 * Switch-driven pixel editor. Navigation presses select a channel and
 * pixel, load the user switch byte and request a write to pixel memory.
 */
`timescale 1ns/1ps
`default_nettype none

`include "led_board_defs.svh"

module pixel_editor (
  input  logic                       main_clk_buf,
  input  logic                       rst_core_ni,
  input  led_board_pkg::nav_sw_t     nav_press_i,
  input  led_board_pkg::usr_sw_t     usr_level_i,
  output logic                       ed_req_o,
  output led_board_pkg::pix_idx_t    ed_idx_o,
  output led_board_pkg::pixel_t      ed_wdata_o,
  input  logic                       ed_gnt_i,
  output led_board_pkg::color_chan_e chan_o,
  output led_board_pkg::pix_idx_t    idx_o
);
  import led_board_pkg::*;

  color_chan_e chan_q;
  pix_idx_t    idx_q;
  pixel_t      color_q;
  logic        req_q;

  function automatic color_chan_e chan_next(input color_chan_e c);
    case (c)
      CHAN_G:  return CHAN_R;
      CHAN_R:  return CHAN_B;
      default: return CHAN_G;
    endcase
  endfunction

  function automatic color_chan_e chan_prev(input color_chan_e c);
    case (c)
      CHAN_G:  return CHAN_B;
      CHAN_B:  return CHAN_R;
      default: return CHAN_G;
    endcase
  endfunction

  always_ff @(posedge main_clk_buf or negedge rst_core_ni) begin
    if (!rst_core_ni) begin
      chan_q  <= CHAN_G;
      idx_q   <= '0;
      color_q <= '0;
      req_q   <= 1'b0;
    end else if (req_q) begin
      // Busy until the write lands; presses are dropped meanwhile.
      if (ed_gnt_i) begin
        req_q <= 1'b0;
      end
    end else begin
      if (nav_press_i[NAV_LEFT]) begin
        chan_q <= chan_prev(chan_q);
      end else if (nav_press_i[NAV_RIGHT]) begin
        chan_q <= chan_next(chan_q);
      end
      if (nav_press_i[NAV_UP]) begin
        case (chan_q)
          CHAN_G:  color_q.g <= usr_level_i;
          CHAN_R:  color_q.r <= usr_level_i;
          default: color_q.b <= usr_level_i;
        endcase
      end
      if (nav_press_i[NAV_DOWN]) begin
        if (idx_q == pix_idx_t'(`LED_COUNT - 1)) begin
          idx_q <= '0;
        end else begin
          idx_q <= idx_q + pix_idx_t'(1);
        end
      end
      if (nav_press_i[NAV_CENTER]) begin
        req_q <= 1'b1;
      end
    end
  end

  assign ed_req_o   = req_q;
  assign ed_idx_o   = idx_q;
  assign ed_wdata_o = color_q;
  assign chan_o     = chan_q;
  assign idx_o      = idx_q;

  req_stable_a: assert property (@(posedge main_clk_buf) disable iff (!rst_core_ni)
    ed_req_o && !ed_gnt_i |=> ed_req_o && $stable(ed_idx_o) && $stable(ed_wdata_o));

endmodule

`default_nettype wire

/* design/pixel_arbiter.sv */
/*
 * Arbiter for the single pixel memory port. The LED driver reads,
 * the editor writes; the driver has fixed priority.
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_arbiter (
  input  logic                    main_clk_buf,
  input  logic                    rst_core_ni,
  // LED driver read port.
  input  logic                    drv_req_i,
  input  led_board_pkg::pix_idx_t drv_idx_i,
  output logic                    drv_gnt_o,
  output led_board_pkg::pixel_t   drv_rdata_o,
  output logic                    drv_rd_valid_o,
  // Editor write port.
  input  logic                    ed_req_i,
  input  led_board_pkg::pix_idx_t ed_idx_i,
  input  led_board_pkg::pixel_t   ed_wdata_i,
  output logic                    ed_gnt_o,
  // Memory side.
  output logic                    ram_en_o,
  output logic                    ram_we_o,
  output led_board_pkg::pix_idx_t ram_addr_o,
  output led_board_pkg::pixel_t   ram_wdata_o,
  input  led_board_pkg::pixel_t   ram_rdata_i
);
  // Requesters drop their level on the clock edge that ends the grant,
  // so a combinational grant is seen as a single-cycle pulse.
  assign drv_gnt_o = drv_req_i;
  assign ed_gnt_o  = ed_req_i & ~drv_req_i;

  assign ram_en_o    = drv_gnt_o | ed_gnt_o;
  assign ram_we_o    = ed_gnt_o;
  assign ram_addr_o  = drv_gnt_o ? drv_idx_i : ed_idx_i;
  assign ram_wdata_o = ed_wdata_i;

  // Read data lands one clock after the driver's grant.
  always_ff @(posedge main_clk_buf or negedge rst_core_ni) begin
    if (!rst_core_ni) begin
      drv_rd_valid_o <= 1'b0;
    end else begin
      drv_rd_valid_o <= drv_gnt_o;
    end
  end

  assign drv_rdata_o = ram_rdata_i;

  // Editor never waits more than one clock behind a driver read.
  ed_wait_a: assert property (@(posedge main_clk_buf) disable iff (!rst_core_ni)
    ed_req_i && !ed_gnt_o |=> ed_gnt_o);

endmodule

`default_nettype wire

/* design/pixel_ram.sv */
/*
 * Pixel frame memory with one port and a registered read.
 * Cleared by reset so the chain starts dark.
 */
`timescale 1ns/1ps
`default_nettype none

`include "led_board_defs.svh"

module pixel_ram (
  input  logic                      main_clk_buf,
  input  logic                      rst_core_ni,
  input  logic                      en_i,
  input  logic                      we_i,
  input  led_board_pkg::pix_idx_t   addr_i,
  input  led_board_pkg::pixel_t     wdata_i,
  output led_board_pkg::pixel_t     rdata_o
);
  import led_board_pkg::*;

  pixel_t mem_q [`LED_COUNT];

  always_ff @(posedge main_clk_buf or negedge rst_core_ni) begin
    if (!rst_core_ni) begin
      for (int i = 0; i < `LED_COUNT; i++) begin
        mem_q[i] <= '0;
      end
      rdata_o <= '0;
    end else if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

/* design/sw_sync.sv */
/*
 * Switch pad synchronizer. Pads are active low; outputs are active high
 * levels and one-clock press pulses. The switch vector type is a parameter.
 */
`timescale 1ns/1ps
`default_nettype none

module sw_sync #(
  parameter type sw_t = logic [7:0]
) (
  input  logic main_clk_buf,
  input  logic rst_core_ni,
  input  sw_t  sw_pad_ni,
  output sw_t  sw_level_o,
  output sw_t  sw_press_o
);
  sw_t meta_q;
  sw_t level_q;
  sw_t prev_q;
  sw_t press_q;

  always_ff @(posedge main_clk_buf or negedge rst_core_ni) begin
    if (!rst_core_ni) begin
      meta_q  <= '0;
      level_q <= '0;
      prev_q  <= '0;
      press_q <= '0;
    end else begin
      meta_q  <= ~sw_pad_ni;
      level_q <= meta_q;
      prev_q  <= level_q;
      // Rising edge of the synchronized level.
      press_q <= level_q & ~prev_q;
    end
  end

  assign sw_level_o = level_q;
  assign sw_press_o = press_q;

endmodule

`default_nettype wire

/* design/rst_ctrl.sv */
/*
 * Core reset generator. Asserts with the board button, releases a fixed
 * number of clocks after the button goes high again.
 */
`timescale 1ns/1ps
`default_nettype none

`include "led_board_defs.svh"

module rst_ctrl (
  input  logic main_clk_buf,
  input  logic rst_sys_n,
  output logic rst_core_no
);
  localparam int CNT_W = $clog2(`RST_HOLD_CYCLES + 1);
  localparam logic [CNT_W-1:0] HOLD = CNT_W'(`RST_HOLD_CYCLES);

  logic [1:0]       sync_q;
  logic [CNT_W-1:0] hold_cnt_q;

  // Button release is synchronized before the hold count starts.
  always_ff @(posedge main_clk_buf or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      sync_q      <= 2'b00;
      hold_cnt_q  <= '0;
      rst_core_no <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
      if (sync_q[1] && hold_cnt_q != HOLD) begin
        hold_cnt_q <= hold_cnt_q + CNT_W'(1);
      end
      if (sync_q[1] && hold_cnt_q == HOLD - CNT_W'(1)) begin
        rst_core_no <= 1'b1;
      end
    end
  end

  hold_low_a: assert property (@(posedge main_clk_buf) disable iff (!rst_sys_n)
    (hold_cnt_q < HOLD) |-> !rst_core_no);

endmodule

`default_nettype wire

/* design/led_board_pkg.sv */
/*
 * Shared types for the LED subsystem: pixel layout, index, channel
 * select and switch vectors. Imported by the RTL blocks and the top level.
 */
`default_nettype none

`include "led_board_defs.svh"

package led_board_pkg;

  // Sent green first, MSB first.
  typedef struct packed {
    logic [7:0] g;
    logic [7:0] r;
    logic [7:0] b;
  } pixel_t;

  typedef logic [$clog2(`LED_COUNT)-1:0] pix_idx_t;

  typedef enum logic [1:0] {
    CHAN_G = 2'd0,
    CHAN_R = 2'd1,
    CHAN_B = 2'd2
  } color_chan_e;

  typedef logic [4:0] nav_sw_t;
  typedef logic [7:0] usr_sw_t;

  // Navigation switch bit positions.
  localparam int NAV_CENTER = 0;
  localparam int NAV_UP     = 1;
  localparam int NAV_DOWN   = 2;
  localparam int NAV_LEFT   = 3;
  localparam int NAV_RIGHT  = 4;

endpackage

`default_nettype wire

/* design/led_board_defs.svh */
/*
 * Board-level constants for the LED subsystem.
 * Include wherever pixel count, WS281x timing or reset length is needed.
 */
`ifndef LED_BOARD_DEFS_SVH
`define LED_BOARD_DEFS_SVH

// Pixels in the serial RGB chain.
`define LED_COUNT 4

// WS281x bit timing in main clock cycles.
`define WS_BIT_CYCLES 63
`define WS_T0H_CYCLES 20
`define WS_T1H_CYCLES 40

// Latch gap after a frame.
`define WS_RESET_CYCLES 2500

// Core reset hold after the button is released.
`define RST_HOLD_CYCLES 32

`endif
